//--- hw/sb_hazard_check.sv
`timescale 1ns/1ps

module sb_hazard_check (
  input  logic                                    instr_valid,
  input  sb_isa_pkg::op_class_e                   op_class,
  input  logic                                    src_fp,
  input  logic [sb_isa_pkg::reg_addr_width_c-1:0] rs1,
  input  logic [sb_isa_pkg::reg_addr_width_c-1:0] rs2,
  input  logic [sb_isa_pkg::reg_addr_width_c-1:0] rd,
  input  sb_mem_pkg::sb_entry_t [sb_isa_pkg::reg_els_c-1:0] int_sb,
  input  sb_mem_pkg::sb_entry_t [sb_isa_pkg::reg_els_c-1:0] float_sb,
  output logic                                    stall_id
);

  logic                  lookup_en;
  logic                  rs1_fp;
  logic                  rs2_used;
  logic                  rd_fp;
  sb_mem_pkg::sb_entry_t rs1_entry;
  sb_mem_pkg::sb_entry_t rs2_entry;
  sb_mem_pkg::sb_entry_t rd_entry;

  always_comb begin
    lookup_en = 1'b1;
    rs1_fp    = src_fp;
    rs2_used  = 1'b1;
    rd_fp     = 1'b0;
    case (op_class)
      // address base always comes from the int file
      sb_isa_pkg::INT_LOAD: begin
        rs1_fp   = 1'b0;
        rs2_used = 1'b0;
      end
      sb_isa_pkg::FP_LOAD: begin
        rs1_fp   = 1'b0;
        rs2_used = 1'b0;
        rd_fp    = 1'b1;
      end
      sb_isa_pkg::AMO: begin
        rs1_fp = 1'b0;
      end
      sb_isa_pkg::FDIV_FSQRT, sb_isa_pkg::PLAIN_FP: begin
        rd_fp = 1'b1;
      end
      sb_isa_pkg::NONE: begin
        lookup_en = 1'b0;
      end
      default: begin
        rd_fp = 1'b0;
      end
    endcase
  end

  assign rs1_entry = rs1_fp ? float_sb[rs1] : int_sb[rs1];
  assign rs2_entry = src_fp ? float_sb[rs2] : int_sb[rs2];
  // waw against a destination still in flight
  assign rd_entry  = rd_fp ? float_sb[rd] : int_sb[rd];

  assign stall_id = instr_valid & lookup_en
    & ((rs1_entry != '0) | (rs2_used & (rs2_entry != '0)) | (rd_entry != '0));

endmodule

//--- hw/sb_instr_decode.sv
`timescale 1ns/1ps

module sb_instr_decode (
  input  logic [sb_isa_pkg::instr_width_c-1:0]    instr,
  output sb_isa_pkg::op_class_e                   op_class,
  output logic [sb_isa_pkg::reg_addr_width_c-1:0] rd,
  output logic [sb_isa_pkg::reg_addr_width_c-1:0] rs1,
  output logic [sb_isa_pkg::reg_addr_width_c-1:0] rs2,
  output logic [sb_isa_pkg::imm_width_c-1:0]      imm,
  output logic                                    src_fp
);

  logic [sb_isa_pkg::opcode_width_c-1:0] opcode;
  logic [sb_isa_pkg::funct3_width_c-1:0] funct3;
  logic [sb_isa_pkg::funct7_width_c-1:0] funct7;
  logic                                  is_idiv;
  logic                                  is_fdiv_fsqrt;

  // standard rv32 field positions
  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  // div, divu, rem, remu
  assign is_idiv = (funct7 == 7'b0000001) && funct3[2];

  // fdiv.s and fsqrt.s
  assign is_fdiv_fsqrt = (funct7 == 7'b0001100) || (funct7 == 7'b0101100);

  always_comb begin
    op_class = sb_isa_pkg::NONE;
    src_fp   = 1'b0;
    imm      = instr[31:20];
    case (opcode)
      sb_isa_pkg::OPC_LOAD: begin
        op_class = sb_isa_pkg::INT_LOAD;
      end
      sb_isa_pkg::OPC_LOAD_FP: begin
        op_class = sb_isa_pkg::FP_LOAD;
      end
      sb_isa_pkg::OPC_AMO: begin
        op_class = sb_isa_pkg::AMO;
        // amo addresses rs1 directly, the upper bits hold funct5/aq/rl
        imm      = '0;
      end
      sb_isa_pkg::OPC_OP: begin
        if (is_idiv) begin
          op_class = sb_isa_pkg::IDIV;
        end else begin
          op_class = sb_isa_pkg::PLAIN_INT;
        end
      end
      sb_isa_pkg::OPC_OP_FP: begin
        src_fp = 1'b1;
        if (is_fdiv_fsqrt) begin
          op_class = sb_isa_pkg::FDIV_FSQRT;
        end else begin
          op_class = sb_isa_pkg::PLAIN_FP;
        end
      end
      default: begin
        op_class = sb_isa_pkg::NONE;
      end
    endcase
  end

endmodule

//--- hw/sb_isa_pkg.sv
package sb_isa_pkg;

  // register file geometry
  localparam int reg_addr_width_c = 5;
  localparam int reg_els_c        = 32;

  // instruction word and field widths
  localparam int instr_width_c  = 32;
  localparam int opcode_width_c = 7;
  localparam int funct3_width_c = 3;
  localparam int funct7_width_c = 7;
  localparam int imm_width_c    = 12;

  // major opcodes seen by the decode stage
  typedef enum logic [opcode_width_c-1:0] {
    OPC_LOAD    = 7'b0000011,
    OPC_LOAD_FP = 7'b0000111,
    OPC_AMO     = 7'b0101111,
    OPC_OP      = 7'b0110011,
    OPC_OP_FP   = 7'b1010011,
    // anything the scoreboard does not care about
    OPC_OTHER   = 7'b0010011
  } opcode_e;

  // operation class, picks the scoreboard bit and the hazard lookups
  typedef enum logic [2:0] {
    INT_LOAD   = 3'd0,
    FP_LOAD    = 3'd1,
    AMO        = 3'd2,
    IDIV       = 3'd3,
    FDIV_FSQRT = 3'd4,
    PLAIN_INT  = 3'd5,
    PLAIN_FP   = 3'd6,
    NONE       = 3'd7
  } op_class_e;

endpackage

//--- hw/sb_mem_pkg.sv
package sb_mem_pkg;

  // remote region of an effective address, from its top bits
  //   1xx -> dram
  //   01x -> global
  //   001 -> group
  //   000 -> local
  typedef enum logic [1:0] {
    LOCAL  = 2'd0,
    GROUP  = 2'd1,
    GLOBAL = 2'd2,
    DRAM   = 2'd3
  } region_e;

  // one scoreboard entry per register
  // bit 3 divide, bit 2 dram, bit 1 global, bit 0 group
  typedef struct packed {
    logic div_busy;
    logic dram_busy;
    logic global_busy;
    logic group_busy;
  } sb_entry_t;

endpackage

//--- hw/sb_retire_merge.sv
`timescale 1ns/1ps

module sb_retire_merge (
  input  logic                                    clk_i,
  input  logic                                    reset_i,

  input  logic                                    idiv_done,
  input  logic [sb_isa_pkg::reg_addr_width_c-1:0] idiv_rd,
  input  logic                                    int_resp_valid,
  input  logic [sb_isa_pkg::reg_addr_width_c-1:0] int_resp_rd,
  input  logic                                    fdiv_done,
  input  logic [sb_isa_pkg::reg_addr_width_c-1:0] fdiv_rd,
  input  logic                                    float_resp_valid,
  input  logic [sb_isa_pkg::reg_addr_width_c-1:0] float_resp_rd,

  output logic                                    int_clear,
  output logic [sb_isa_pkg::reg_addr_width_c-1:0] int_clear_id,
  output logic                                    float_clear,
  output logic [sb_isa_pkg::reg_addr_width_c-1:0] float_clear_id
);

  // index 0 is the int file, index 1 the float file
  logic [1:0]                                    pri_v;
  logic [1:0][sb_isa_pkg::reg_addr_width_c-1:0] pri_id;
  logic [1:0]                                    sec_v;
  logic [1:0][sb_isa_pkg::reg_addr_width_c-1:0] sec_id;
  logic [1:0]                                    clear_v;
  logic [1:0][sb_isa_pkg::reg_addr_width_c-1:0] clear_id;
  logic [1:0]                                    hold_v_r;
  logic [1:0][sb_isa_pkg::reg_addr_width_c-1:0] hold_id_r;

  // divider units are the primary source, responses the secondary
  assign pri_v  = {fdiv_done, idiv_done};
  assign pri_id = {fdiv_rd, idiv_rd};
  assign sec_v  = {float_resp_valid, int_resp_valid};
  assign sec_id = {float_resp_rd, int_resp_rd};

  for (genvar f = 0; f < 2; f++) begin : g_file
    // held slot, then primary, then secondary
    assign clear_v[f]  = hold_v_r[f] | pri_v[f] | sec_v[f];
    assign clear_id[f] = hold_v_r[f] ? hold_id_r[f] :
                         pri_v[f]    ? pri_id[f]    : sec_id[f];

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        hold_v_r[f] <= 1'b0;
      end else if (hold_v_r[f]) begin
        // rate rule leaves no new pulse while the slot drains
        hold_v_r[f] <= pri_v[f] | sec_v[f];
      end else begin
        hold_v_r[f] <= pri_v[f] & sec_v[f];
      end
    end

    // the loser of this cycle waits in the slot
    always_ff @(posedge clk_i) begin
      if (hold_v_r[f] && pri_v[f]) begin
        hold_id_r[f] <= pri_id[f];
      end else if (hold_v_r[f] || pri_v[f]) begin
        hold_id_r[f] <= sec_id[f];
      end
    end
  end

  assign int_clear      = clear_v[0];
  assign int_clear_id   = clear_id[0];
  assign float_clear    = clear_v[1];
  assign float_clear_id = clear_id[1];

endmodule

//--- hw/sb_scoreboard_tracker.sv
`timescale 1ns/1ps

module sb_scoreboard_tracker #(
  parameter int data_width_p = 32
) (
  input  logic                                    clk_i,
  input  logic                                    reset_i,

  input  logic                                    instr_valid,
  input  logic                                    flush,
  input  logic                                    stall_all,
  input  logic                                    stall_id,

  input  logic [data_width_p-1:0]                 rs1_val,
  input  sb_isa_pkg::op_class_e                   op_class,
  input  logic [sb_isa_pkg::reg_addr_width_c-1:0] rd,
  input  logic [sb_isa_pkg::imm_width_c-1:0]      imm,

  input  logic                                    int_clear,
  input  logic [sb_isa_pkg::reg_addr_width_c-1:0] int_clear_id,
  input  logic                                    float_clear,
  input  logic [sb_isa_pkg::reg_addr_width_c-1:0] float_clear_id,

  output logic                                    issue,
  output sb_mem_pkg::sb_entry_t [sb_isa_pkg::reg_els_c-1:0] int_sb,
  output sb_mem_pkg::sb_entry_t [sb_isa_pkg::reg_els_c-1:0] float_sb
);

  sb_mem_pkg::sb_entry_t [sb_isa_pkg::reg_els_c-1:0] int_sb_r;
  sb_mem_pkg::sb_entry_t [sb_isa_pkg::reg_els_c-1:0] float_sb_r;

  logic [data_width_p-1:0] mem_addr;
  sb_mem_pkg::region_e     region;
  sb_mem_pkg::sb_entry_t   region_set;
  sb_mem_pkg::sb_entry_t   int_set;
  sb_mem_pkg::sb_entry_t   float_set;
  sb_mem_pkg::sb_entry_t   int_rd_base;
  sb_mem_pkg::sb_entry_t   float_rd_base;

  assign issue = instr_valid & ~stall_id & ~stall_all & ~flush;

  // effective address, rs1 plus sign extended offset
  assign mem_addr = rs1_val
    + {{(data_width_p-sb_isa_pkg::imm_width_c){imm[sb_isa_pkg::imm_width_c-1]}}, imm};

  // only the top bits matter, so any data width works
  always_comb begin
    if (mem_addr[data_width_p-1]) begin
      region = sb_mem_pkg::DRAM;
    end else if (mem_addr[data_width_p-1-:2] == 2'b01) begin
      region = sb_mem_pkg::GLOBAL;
    end else if (mem_addr[data_width_p-1-:3] == 3'b001) begin
      region = sb_mem_pkg::GROUP;
    end else begin
      region = sb_mem_pkg::LOCAL;
    end
  end

  always_comb begin
    region_set = '0;
    case (region)
      sb_mem_pkg::DRAM:   region_set.dram_busy   = 1'b1;
      sb_mem_pkg::GLOBAL: region_set.global_busy = 1'b1;
      sb_mem_pkg::GROUP:  region_set.group_busy  = 1'b1;
      // local loads come back in fixed time
      default:            region_set = '0;
    endcase
  end

  // bit to set in each file for the instruction in decode
  always_comb begin
    int_set   = '0;
    float_set = '0;
    case (op_class)
      sb_isa_pkg::IDIV: begin
        int_set.div_busy = 1'b1;
      end
      sb_isa_pkg::INT_LOAD: begin
        // load to x0 never writes back
        if (rd != '0) begin
          int_set = region_set;
        end
      end
      sb_isa_pkg::AMO: begin
        int_set = region_set;
      end
      sb_isa_pkg::FP_LOAD: begin
        float_set = region_set;
      end
      sb_isa_pkg::FDIV_FSQRT: begin
        float_set.div_busy = 1'b1;
      end
      default: begin
        int_set   = '0;
        float_set = '0;
      end
    endcase
  end

  // clear goes first when it hits the register being set
  assign int_rd_base   = (int_clear && (int_clear_id == rd)) ? '0 : int_sb_r[rd];
  assign float_rd_base = (float_clear && (float_clear_id == rd)) ? '0 : float_sb_r[rd];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      int_sb_r   <= '0;
      float_sb_r <= '0;
    end else begin
      if (int_clear) begin
        int_sb_r[int_clear_id] <= '0;
      end
      if (issue && (int_set != '0)) begin
        int_sb_r[rd] <= int_rd_base | int_set;
      end

      if (float_clear) begin
        float_sb_r[float_clear_id] <= '0;
      end
      if (issue && (float_set != '0)) begin
        float_sb_r[rd] <= float_rd_base | float_set;
      end
    end
  end

  assign int_sb   = int_sb_r;
  assign float_sb = float_sb_r;

endmodule

//--- hw/sb_top.sv
`timescale 1ns/1ps

module sb_top #(
  parameter int data_width_p = 32
) (
  input  logic                                    clk_i,
  input  logic                                    reset_i,

  input  logic                                    instr_valid,
  input  logic [sb_isa_pkg::instr_width_c-1:0]    instr,
  input  logic [data_width_p-1:0]                 rs1_val,
  input  logic                                    flush,
  input  logic                                    stall_all,

  input  logic                                    idiv_done,
  input  logic [sb_isa_pkg::reg_addr_width_c-1:0] idiv_rd,
  input  logic                                    int_resp_valid,
  input  logic [sb_isa_pkg::reg_addr_width_c-1:0] int_resp_rd,
  input  logic                                    fdiv_done,
  input  logic [sb_isa_pkg::reg_addr_width_c-1:0] fdiv_rd,
  input  logic                                    float_resp_valid,
  input  logic [sb_isa_pkg::reg_addr_width_c-1:0] float_resp_rd,

  output logic                                    issue,
  output logic                                    stall_id,
  output sb_mem_pkg::sb_entry_t [sb_isa_pkg::reg_els_c-1:0] int_sb,
  output sb_mem_pkg::sb_entry_t [sb_isa_pkg::reg_els_c-1:0] float_sb
);

  // decode fields
  sb_isa_pkg::op_class_e                   op_class;
  logic [sb_isa_pkg::reg_addr_width_c-1:0] rd;
  logic [sb_isa_pkg::reg_addr_width_c-1:0] rs1;
  logic [sb_isa_pkg::reg_addr_width_c-1:0] rs2;
  logic [sb_isa_pkg::imm_width_c-1:0]      imm;
  logic                                    src_fp;

  // merged completions
  logic                                    int_clear;
  logic [sb_isa_pkg::reg_addr_width_c-1:0] int_clear_id;
  logic                                    float_clear;
  logic [sb_isa_pkg::reg_addr_width_c-1:0] float_clear_id;

  sb_instr_decode u_decode (
    .instr    (instr),
    .op_class (op_class),
    .rd       (rd),
    .rs1      (rs1),
    .rs2      (rs2),
    .imm      (imm),
    .src_fp   (src_fp)
  );

  sb_hazard_check u_hazard (
    .instr_valid (instr_valid),
    .op_class    (op_class),
    .src_fp      (src_fp),
    .rs1         (rs1),
    .rs2         (rs2),
    .rd          (rd),
    .int_sb      (int_sb),
    .float_sb    (float_sb),
    .stall_id    (stall_id)
  );

  sb_scoreboard_tracker #(
    .data_width_p (data_width_p)
  ) u_tracker (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_valid    (instr_valid),
    .flush          (flush),
    .stall_all      (stall_all),
    .stall_id       (stall_id),
    .rs1_val        (rs1_val),
    .op_class       (op_class),
    .rd             (rd),
    .imm            (imm),
    .int_clear      (int_clear),
    .int_clear_id   (int_clear_id),
    .float_clear    (float_clear),
    .float_clear_id (float_clear_id),
    .issue          (issue),
    .int_sb         (int_sb),
    .float_sb       (float_sb)
  );

  sb_retire_merge u_merge (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .idiv_done        (idiv_done),
    .idiv_rd          (idiv_rd),
    .int_resp_valid   (int_resp_valid),
    .int_resp_rd      (int_resp_rd),
    .fdiv_done        (fdiv_done),
    .fdiv_rd          (fdiv_rd),
    .float_resp_valid (float_resp_valid),
    .float_resp_rd    (float_resp_rd),
    .int_clear        (int_clear),
    .int_clear_id     (int_clear_id),
    .float_clear      (float_clear),
    .float_clear_id   (float_clear_id)
  );

endmodule

//--- project.f
hw/sb_isa_pkg.sv
hw/sb_mem_pkg.sv
hw/sb_instr_decode.sv
hw/sb_scoreboard_tracker.sv
hw/sb_hazard_check.sv
hw/sb_retire_merge.sv
hw/sb_top.sv
test/sb_clock_gen.sv
test/sb_tb_sva.sv
test/sb_tb.sv

//--- test/sb_clock_gen.sv
`timescale 1ns/1ps

module sb_clock_gen (
  output logic clk_i,
  output logic reset_i
);

  // 20 ns period
  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    reset_i = 1'b1;
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
  end

endmodule

//--- test/sb_tb.sv
`timescale 1ns/1ps

module sb_tb;

  localparam int dw_c = 32;
  localparam int aw_c = sb_isa_pkg::reg_addr_width_c;
  // directed tests 1 to 5, then the random run and its drain
  localparam int test_len_c  = 4 + 20 + 10 + 10 + 16 + 12 + 300 + 3;
  localparam int run_limit_c = test_len_c + 50;

  typedef sb_mem_pkg::sb_entry_t [sb_isa_pkg::reg_els_c-1:0] sb_arr_t;

  logic clk_i, reset_i;
  logic instr_valid, flush, stall_all;
  logic [31:0] instr;
  logic [dw_c-1:0] rs1_val;
  logic idiv_done, int_resp_valid, fdiv_done, float_resp_valid;
  logic [aw_c-1:0] idiv_rd, int_resp_rd, fdiv_rd, float_resp_rd;
  logic issue, stall_id;
  sb_arr_t int_sb, float_sb;

  // model view of the instruction in decode
  sb_isa_pkg::op_class_e m_class;
  logic [aw_c-1:0] m_rd, m_rs1, m_rs2;
  logic [11:0] m_imm;
  sb_arr_t exp_int, exp_fp;
  logic [1:0] hold_v;
  logic [1:0][aw_c-1:0] hold_id;
  logic st, iss, c_int, c_fp;
  logic [aw_c-1:0] c_int_id, c_fp_id;
  logic [dw_c-1:0] ea;
  int errors, checks, test_start, cycles;
  int prev_cnt [2];
  integer seed = 32'haa84;

  sb_clock_gen u_clk (.clk_i(clk_i), .reset_i(reset_i));

  sb_top #(.data_width_p(dw_c)) DUT (
    .clk_i(clk_i), .reset_i(reset_i), .instr_valid(instr_valid), .instr(instr),
    .rs1_val(rs1_val), .flush(flush), .stall_all(stall_all),
    .idiv_done(idiv_done), .idiv_rd(idiv_rd),
    .int_resp_valid(int_resp_valid), .int_resp_rd(int_resp_rd),
    .fdiv_done(fdiv_done), .fdiv_rd(fdiv_rd),
    .float_resp_valid(float_resp_valid), .float_resp_rd(float_resp_rd),
    .issue(issue), .stall_id(stall_id), .int_sb(int_sb), .float_sb(float_sb)
  );

  function automatic logic [31:0] make_instr(sb_isa_pkg::op_class_e c, logic [4:0] d,
                                             logic [4:0] a, logic [4:0] b, logic [11:0] imm);
    case (c)
      sb_isa_pkg::INT_LOAD:   return {imm, a, 3'b010, d, sb_isa_pkg::OPC_LOAD};
      sb_isa_pkg::FP_LOAD:    return {imm, a, 3'b010, d, sb_isa_pkg::OPC_LOAD_FP};
      sb_isa_pkg::AMO:        return {7'b0000100, b, a, 3'b010, d, sb_isa_pkg::OPC_AMO};
      sb_isa_pkg::IDIV:       return {7'b0000001, b, a, 3'b100, d, sb_isa_pkg::OPC_OP};
      sb_isa_pkg::FDIV_FSQRT: return {7'b0001100, b, a, 3'b111, d, sb_isa_pkg::OPC_OP_FP};
      sb_isa_pkg::PLAIN_INT:  return {7'b0000000, b, a, 3'b000, d, sb_isa_pkg::OPC_OP};
      sb_isa_pkg::PLAIN_FP:   return {7'b0000000, b, a, 3'b000, d, sb_isa_pkg::OPC_OP_FP};
      default:                return {imm, a, 3'b000, d, sb_isa_pkg::OPC_OTHER};
    endcase
  endfunction

  function automatic sb_mem_pkg::sb_entry_t region_bit(logic [dw_c-1:0] a);
    sb_mem_pkg::sb_entry_t e;
    e = '0;
    if (a[dw_c-1]) e.dram_busy = 1'b1;
    else if (a[dw_c-2]) e.global_busy = 1'b1;
    else if (a[dw_c-3]) e.group_busy = 1'b1;
    return e;
  endfunction

  function automatic sb_mem_pkg::sb_entry_t set_val(logic fp_file, sb_isa_pkg::op_class_e c,
                                                    logic [4:0] d, logic [dw_c-1:0] a);
    sb_mem_pkg::sb_entry_t e;
    e = '0;
    if (!fp_file && c == sb_isa_pkg::IDIV) e.div_busy = 1'b1;
    if (!fp_file && ((c == sb_isa_pkg::INT_LOAD && d != 0) || c == sb_isa_pkg::AMO))
      e = region_bit(a);
    if (fp_file && c == sb_isa_pkg::FDIV_FSQRT) e.div_busy = 1'b1;
    if (fp_file && c == sb_isa_pkg::FP_LOAD) e = region_bit(a);
    return e;
  endfunction

  function automatic logic exp_stall(logic v, sb_isa_pkg::op_class_e c,
                                     logic [4:0] a, logic [4:0] b, logic [4:0] d);
    logic fp_src, fp_dst, use_b;
    sb_mem_pkg::sb_entry_t e1, e2, e3;
    if (!v || c == sb_isa_pkg::NONE) return 1'b0;
    fp_src = (c == sb_isa_pkg::FDIV_FSQRT) || (c == sb_isa_pkg::PLAIN_FP);
    fp_dst = fp_src || (c == sb_isa_pkg::FP_LOAD);
    use_b  = !(c == sb_isa_pkg::INT_LOAD || c == sb_isa_pkg::FP_LOAD);
    e1 = fp_src ? exp_fp[a] : exp_int[a];
    e2 = fp_src ? exp_fp[b] : exp_int[b];
    e3 = fp_dst ? exp_fp[d] : exp_int[d];
    return (e1 != 0) || (use_b && e2 != 0) || (e3 != 0);
  endfunction

  // clear first, then the new bit
  function automatic sb_arr_t next_sb(sb_arr_t prev, logic clr, logic [4:0] clr_id,
                                      logic do_set, logic [4:0] d, sb_mem_pkg::sb_entry_t s);
    sb_arr_t r;
    r = prev;
    if (clr) r[clr_id] = '0;
    if (do_set) r[d] = r[d] | s;
    return r;
  endfunction

  // slot, then divider, then response
  task automatic merge_step(input int f, input logic pv, input logic [4:0] pid,
                            input logic sv, input logic [4:0] sid,
                            output logic clr, output logic [4:0] clr_id);
    logic [4:0] ids [$];
    if (hold_v[f]) ids.push_back(hold_id[f]);
    if (pv) ids.push_back(pid);
    if (sv) ids.push_back(sid);
    clr = ids.size() > 0;
    clr_id = clr ? ids[0] : '0;
    hold_v[f] = ids.size() > 1;
    if (ids.size() > 1) hold_id[f] = ids[1];
  endtask

  task automatic check_entry_array(string name, sb_arr_t got, sb_arr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // compare mismatches plus assertion failures in the bound checker
  function automatic int total_errors();
    return errors + DUT.u_sva.fail_count;
  endfunction

  always @(negedge clk_i) begin
    if (reset_i) begin
      exp_int = '0;
      exp_fp  = '0;
      hold_v  = '0;
    end else begin
      st  = exp_stall(instr_valid, m_class, m_rs1, m_rs2, m_rd);
      iss = instr_valid & ~st & ~flush & ~stall_all;
      ea  = rs1_val + {{(dw_c-12){m_imm[11]}}, m_imm};
      check_entry_array("int_sb", int_sb, exp_int);
      check_entry_array("float_sb", float_sb, exp_fp);
      check_bit("stall_id", stall_id, st);
      check_bit("issue", issue, iss);
      merge_step(0, idiv_done, idiv_rd, int_resp_valid, int_resp_rd, c_int, c_int_id);
      merge_step(1, fdiv_done, fdiv_rd, float_resp_valid, float_resp_rd, c_fp, c_fp_id);
      exp_int = next_sb(exp_int, c_int, c_int_id, iss, m_rd, set_val(0, m_class, m_rd, ea));
      exp_fp  = next_sb(exp_fp, c_fp, c_fp_id, iss, m_rd, set_val(1, m_class, m_rd, ea));
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= run_limit_c) begin
      $display("timeout: run did not finish within %0d cycles", run_limit_c);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic tick();
    @(posedge clk_i);
    instr_valid      <= 1'b0;
    flush            <= 1'b0;
    stall_all        <= 1'b0;
    idiv_done        <= 1'b0;
    int_resp_valid   <= 1'b0;
    fdiv_done        <= 1'b0;
    float_resp_valid <= 1'b0;
  endtask

  task automatic idle(int n);
    repeat (n) tick();
  endtask

  task automatic send(sb_isa_pkg::op_class_e c, logic [4:0] d, logic [4:0] a, logic [4:0] b,
                      logic [11:0] imm, logic [dw_c-1:0] val);
    instr_valid <= 1'b1;
    instr       <= make_instr(c, d, a, b, imm);
    rs1_val     <= val;
    m_class     <= c;
    m_rd        <= d;
    m_rs1       <= a;
    m_rs2       <= b;
    m_imm       <= (c == sb_isa_pkg::AMO) ? 12'h000 : imm;
  endtask

  // source 0 idiv, 1 int response, 2 fdiv, 3 float response
  task automatic done(int src, logic [4:0] d);
    case (src)
      0: begin
        idiv_done <= 1'b1;
        idiv_rd   <= d;
      end
      1: begin
        int_resp_valid <= 1'b1;
        int_resp_rd    <= d;
      end
      2: begin
        fdiv_done <= 1'b1;
        fdiv_rd   <= d;
      end
      default: begin
        float_resp_valid <= 1'b1;
        float_resp_rd    <= d;
      end
    endcase
  endtask

  task automatic random_done(int f);
    logic pv, sv;
    pv = ($random(seed) & 3) == 0;
    sv = ($random(seed) & 3) == 0;
    if (prev_cnt[f] + pv + sv > 2) sv = 1'b0;
    if (prev_cnt[f] + pv > 2) pv = 1'b0;
    if (pv) done(2 * f, 5'($random(seed)));
    if (sv) done(2 * f + 1, 5'($random(seed)));
    prev_cnt[f] = pv + sv;
  endtask

  task automatic random_cycle();
    sb_isa_pkg::op_class_e c;
    c = sb_isa_pkg::op_class_e'($random(seed) & 7);
    if (($random(seed) & 3) != 0)
      send(c, 5'($random(seed)), 5'($random(seed)), 5'($random(seed)),
           12'($random(seed)), $random(seed));
    flush     <= ($random(seed) & 15) == 0;
    stall_all <= ($random(seed) & 15) == 0;
    random_done(0);
    random_done(1);
  endtask

  task automatic finish_test(string name);
    $display("test %s: %0d errors", name, total_errors() - test_start);
    test_start = total_errors();
  endtask

  initial begin
    instr_valid      = 1'b0;
    instr            = '0;
    rs1_val          = '0;
    flush            = 1'b0;
    stall_all        = 1'b0;
    idiv_done        = 1'b0;
    idiv_rd          = '0;
    int_resp_valid   = 1'b0;
    int_resp_rd      = '0;
    fdiv_done        = 1'b0;
    fdiv_rd          = '0;
    float_resp_valid = 1'b0;
    float_resp_rd    = '0;
    m_class          = sb_isa_pkg::NONE;
    m_rd             = '0;
    m_rs1            = '0;
    m_rs2            = '0;
    m_imm            = '0;
    errors           = 0;
    checks           = 0;
    test_start       = 0;
    cycles           = 0;
    prev_cnt[0]      = 0;
    prev_cnt[1]      = 0;
    wait (reset_i == 1'b0);
    idle(2);
    // one instruction per region and class
    tick();
    send(sb_isa_pkg::INT_LOAD, 1, 10, 0, 12'h000, 32'h0000_1000);
    tick();
    send(sb_isa_pkg::INT_LOAD, 0, 10, 0, 12'h000, 32'h8000_0000);
    tick();
    send(sb_isa_pkg::INT_LOAD, 2, 10, 0, 12'h000, 32'h8000_0000);
    tick();
    send(sb_isa_pkg::INT_LOAD, 3, 10, 0, 12'h000, 32'h4000_0000);
    tick();
    send(sb_isa_pkg::INT_LOAD, 4, 10, 0, 12'hff8, 32'h4000_0004);
    tick();
    send(sb_isa_pkg::AMO, 5, 10, 11, 12'h000, 32'h9000_0000);
    tick();
    send(sb_isa_pkg::FP_LOAD, 6, 10, 0, 12'h000, 32'h4000_0000);
    tick();
    send(sb_isa_pkg::FP_LOAD, 7, 10, 0, 12'h000, 32'h2000_0000);
    tick();
    send(sb_isa_pkg::FP_LOAD, 8, 10, 0, 12'h000, 32'h0000_0100);
    for (int i = 0; i < 4; i++) begin
      tick();
      done(1, 2 + i);
      if (i < 2) done(3, 6 + i);
    end
    idle(2);
    finish_test("region sets");
    tick();
    send(sb_isa_pkg::IDIV, 8, 1, 2, 12'h000, '0);
    tick();
    send(sb_isa_pkg::FDIV_FSQRT, 9, 1, 2, 12'h000, '0);
    idle(3);
    tick();
    done(0, 8);
    done(2, 9);
    idle(2);
    finish_test("divide set and clear");
    tick();
    send(sb_isa_pkg::IDIV, 10, 1, 2, 12'h000, '0);
    tick();
    send(sb_isa_pkg::INT_LOAD, 11, 1, 0, 12'h000, 32'h8000_0000);
    tick();
    send(sb_isa_pkg::FDIV_FSQRT, 12, 1, 2, 12'h000, '0);
    tick();
    send(sb_isa_pkg::FP_LOAD, 13, 1, 0, 12'h000, 32'h4000_0000);
    tick();
    done(0, 10);
    done(1, 11);
    done(2, 12);
    done(3, 13);
    idle(4);
    finish_test("merge and holding slot");
    tick();
    send(sb_isa_pkg::IDIV, 14, 1, 2, 12'h000, '0);
    repeat (3) begin
      tick();
      send(sb_isa_pkg::PLAIN_INT, 16, 14, 2, 12'h000, '0);
    end
    tick();
    send(sb_isa_pkg::PLAIN_INT, 16, 14, 2, 12'h000, '0);
    done(0, 14);
    repeat (2) begin
      tick();
      send(sb_isa_pkg::PLAIN_INT, 16, 14, 2, 12'h000, '0);
    end
    tick();
    send(sb_isa_pkg::FP_LOAD, 15, 1, 0, 12'h000, 32'h8000_0000);
    repeat (2) begin
      tick();
      send(sb_isa_pkg::FDIV_FSQRT, 15, 1, 2, 12'h000, '0);
    end
    tick();
    send(sb_isa_pkg::FDIV_FSQRT, 15, 1, 2, 12'h000, '0);
    done(3, 15);
    tick();
    send(sb_isa_pkg::FDIV_FSQRT, 15, 1, 2, 12'h000, '0);
    tick();
    done(2, 15);
    idle(2);
    finish_test("hazard stall");
    tick();
    send(sb_isa_pkg::IDIV, 17, 1, 2, 12'h000, '0);
    tick();
    send(sb_isa_pkg::IDIV, 18, 1, 2, 12'h000, '0);
    flush <= 1'b1;
    tick();
    send(sb_isa_pkg::IDIV, 19, 1, 2, 12'h000, '0);
    stall_all <= 1'b1;
    done(0, 17);
    tick();
    send(sb_isa_pkg::IDIV, 20, 1, 2, 12'h000, '0);
    done(1, 20);
    idle(3);
    tick();
    done(0, 20);
    idle(2);
    finish_test("flush and stall_all");
    repeat (300) begin
      tick();
      random_cycle();
    end
    idle(3);
    finish_test("random run");
    $display("checks %0d, errors %0d", checks, total_errors());
    if (total_errors() == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- test/sb_tb_sva.sv
`timescale 1ns/1ps

module sb_tb_sva (
  input logic clk_i,
  input logic reset_i,
  input logic stall_id,
  input logic flush,
  input logic stall_all,
  input logic idiv_done,
  input logic int_resp_valid,
  input logic fdiv_done,
  input logic float_resp_valid,
  input sb_mem_pkg::sb_entry_t [sb_isa_pkg::reg_els_c-1:0] int_sb,
  input sb_mem_pkg::sb_entry_t [sb_isa_pkg::reg_els_c-1:0] float_sb
);

  int fail_count = 0;

  // both scoreboards empty right after reset
  a_reset_clean: assert property (@(posedge clk_i)
    $fell(reset_i) |-> (int_sb == '0) && (float_sb == '0))
    else begin
      $error("scoreboard not empty after reset");
      fail_count++;
    end

  // a blocked cycle only clears bits
  a_blocked_no_set: assert property (@(posedge clk_i) disable iff (reset_i)
    (stall_id || flush || stall_all) |=>
      ((int_sb & ~$past(int_sb)) == '0) && ((float_sb & ~$past(float_sb)) == '0))
    else begin
      $error("scoreboard bit set while blocked");
      fail_count++;
    end

  // at most two completions per file in two cycles
  a_int_rate: assert property (@(posedge clk_i) disable iff (reset_i)
    $countones({idiv_done, int_resp_valid, $past(idiv_done), $past(int_resp_valid)}) <= 2)
    else begin
      $error("int completion rate exceeded");
      fail_count++;
    end

  a_float_rate: assert property (@(posedge clk_i) disable iff (reset_i)
    $countones({fdiv_done, float_resp_valid, $past(fdiv_done), $past(float_resp_valid)}) <= 2)
    else begin
      $error("float completion rate exceeded");
      fail_count++;
    end

endmodule

bind sb_top sb_tb_sva u_sva (
  .clk_i            (clk_i),
  .reset_i          (reset_i),
  .stall_id         (stall_id),
  .flush            (flush),
  .stall_all        (stall_all),
  .idiv_done        (idiv_done),
  .int_resp_valid   (int_resp_valid),
  .fdiv_done        (fdiv_done),
  .float_resp_valid (float_resp_valid),
  .int_sb           (int_sb),
  .float_sb         (float_sb)
);
